// File: rtl/rv32i_macros.svh
`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

// datapath and address width
`define XLEN 32

// architectural registers, x0 included
`define NUM_REGS 32

// fetch queue entries, also the credits owned by fetch after reset
`define FQ_DEPTH 4

`endif

// File: rtl/rv32i_types_pkg.sv
`include "rv32i_macros.svh"

package rv32i_types_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0]       reg_idx_t;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_e;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_e;

    // matches funct3 except sra and sub, which borrow the slt slots
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops_e;

    typedef enum logic {
        cmp_rs2   = 1'b0,
        cmp_i_imm = 1'b1
    } cmpmux_sel_e;

    typedef struct packed {
        rv32i_opcode_e  opcode;
        alu_ops_e       aluop;
        branch_funct3_e cmpop;
        cmpmux_sel_e    cmpmux_sel;
        logic           load_regfile;
        logic           mem_read;
        logic           mem_write;
        logic [3:0]     mem_byte_en;
    } ctrl_word_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_pkt_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        word_t      instr;
        ctrl_word_t ctrl;
        word_t      rs1_val;
        word_t      rs2_val;
        word_t      i_imm;
        word_t      s_imm;
        word_t      b_imm;
        word_t      u_imm;
        word_t      j_imm;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic       br_en;
        word_t      br_addr;
    } id_ex_t;

    // addi x0, x0, 0 in effect, no side effects downstream
    localparam ctrl_word_t nop_ctrl = '{
        opcode:       op_imm,
        aluop:        alu_add,
        cmpop:        beq,
        cmpmux_sel:   cmp_rs2,
        load_regfile: 1'b0,
        mem_read:     1'b0,
        mem_write:    1'b0,
        mem_byte_en:  4'b0000
    };

endpackage : rv32i_types_pkg

// File: rtl/fetch_queue.sv
`include "rv32i_macros.svh"

module fetch_queue (
    input  logic                        clk,
    input  logic                        rst_i,
    input  rv32i_types_pkg::fetch_pkt_t fetch_i,
    input  logic                        pop_i,
    output rv32i_types_pkg::fetch_pkt_t head_o,
    output logic                        not_empty_o,
    output logic                        credit_o
);
    import rv32i_types_pkg::*;

    localparam int PTR_W = $clog2(`FQ_DEPTH);
    localparam int CNT_W = $clog2(`FQ_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    fetch_pkt_t entries [`FQ_DEPTH];
    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    cnt_t       count;
    logic       push;
    logic       pop;

    function automatic ptr_t ptr_inc(input ptr_t p);
        ptr_inc = (p == ptr_t'(`FQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push = fetch_i.valid;              // sender holds a credit
    assign pop  = pop_i && not_empty_o;

    assign not_empty_o = (count != '0);
    assign credit_o    = pop;                 // one credit back per pop

    always_comb begin
        head_o       = entries[rd_ptr];
        head_o.valid = not_empty_o;
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= fetch_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // idle or push and pop together
            endcase
        end
    end

endmodule : fetch_queue

// File: rtl/control_rom.sv
module control_rom (
    input  rv32i_types_pkg::rv32i_opcode_e opcode_i,
    input  logic [2:0]                     funct3_i,
    input  logic [6:0]                     funct7_i,
    output rv32i_types_pkg::ctrl_word_t    ctrl_o
);
    import rv32i_types_pkg::*;

    // byte lanes from the access size in funct3[1:0]
    function automatic logic [3:0] size_mask(input logic [1:0] size);
        case (size)
            2'b00:   size_mask = 4'b0001;
            2'b01:   size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    endfunction

    always_comb begin
        ctrl_o        = nop_ctrl;
        ctrl_o.opcode = opcode_i;

        case (opcode_i)
            op_lui, op_auipc, op_jal, op_jalr: begin
                ctrl_o.load_regfile = 1'b1;
            end

            op_br: begin
                ctrl_o.cmpop      = branch_funct3_e'(funct3_i);
                ctrl_o.cmpmux_sel = cmp_rs2;
            end

            op_load: begin
                ctrl_o.mem_read     = 1'b1;
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.mem_byte_en  = size_mask(funct3_i[1:0]); // lbu/lhu share lanes
            end

            op_store: begin
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.mem_byte_en = size_mask(funct3_i[1:0]);
            end

            op_imm: begin
                ctrl_o.load_regfile = 1'b1;
                case (funct3_i)
                    3'b010: begin                   // slti
                        ctrl_o.cmpop      = blt;
                        ctrl_o.cmpmux_sel = cmp_i_imm;
                    end
                    3'b011: begin                   // sltiu
                        ctrl_o.cmpop      = bltu;
                        ctrl_o.cmpmux_sel = cmp_i_imm;
                    end
                    3'b101: begin
                        ctrl_o.aluop = funct7_i[5] ? alu_sra : alu_srl;
                    end
                    default: begin
                        ctrl_o.aluop = alu_ops_e'(funct3_i);
                    end
                endcase
            end

            op_reg: begin
                ctrl_o.load_regfile = 1'b1;
                case (funct3_i)
                    3'b000: begin
                        ctrl_o.aluop = funct7_i[5] ? alu_sub : alu_add;
                    end
                    3'b010: begin                   // slt
                        ctrl_o.cmpop      = blt;
                        ctrl_o.cmpmux_sel = cmp_rs2;
                    end
                    3'b011: begin                   // sltu
                        ctrl_o.cmpop      = bltu;
                        ctrl_o.cmpmux_sel = cmp_rs2;
                    end
                    3'b101: begin
                        ctrl_o.aluop = funct7_i[5] ? alu_sra : alu_srl;
                    end
                    default: begin
                        ctrl_o.aluop = alu_ops_e'(funct3_i);
                    end
                endcase
            end

            default: begin
                ctrl_o = nop_ctrl;                  // unknown opcode
            end
        endcase
    end

endmodule : control_rom

// File: rtl/regfile.sv
`include "rv32i_macros.svh"

module regfile (
    input  logic                      clk,
    input  logic                      rst_i,
    input  rv32i_types_pkg::wb_pkt_t  wb_i,
    input  rv32i_types_pkg::reg_idx_t rs1_i,
    input  rv32i_types_pkg::reg_idx_t rs2_i,
    output rv32i_types_pkg::word_t    rs1_val_o,
    output rv32i_types_pkg::word_t    rs2_val_o
);
    import rv32i_types_pkg::*;

    word_t regs [`NUM_REGS];
    logic  wr_en;

    assign wr_en = wb_i.valid && (wb_i.rd != '0);   // x0 stays zero

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // write-first, same-cycle writeback wins
    assign rs1_val_o = (wr_en && wb_i.rd == rs1_i) ? wb_i.data : regs[rs1_i];
    assign rs2_val_o = (wr_en && wb_i.rd == rs2_i) ? wb_i.data : regs[rs2_i];

endmodule : regfile

// File: rtl/decode_stage.sv
module decode_stage (
    input  logic                        clk,
    input  logic                        rst_i,
    input  rv32i_types_pkg::fetch_pkt_t fetch_i,
    input  logic                        not_empty_i,
    input  logic                        stall_i,
    input  logic                        flush_i,
    input  rv32i_types_pkg::wb_pkt_t    wb_i,
    output logic                        pop_o,
    output rv32i_types_pkg::id_ex_t     id_ex_o
);
    import rv32i_types_pkg::*;

    rv32i_opcode_e opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    word_t         i_imm;
    word_t         s_imm;
    word_t         b_imm;
    word_t         u_imm;
    word_t         j_imm;
    reg_idx_t      rs1;
    reg_idx_t      rs2;
    reg_idx_t      rd;
    word_t         rs1_val;
    word_t         rs2_val;
    word_t         cmp_b;
    logic          cmp_res;
    ctrl_word_t    rom_ctrl;
    id_ex_t        id_next;

    assign pop_o = not_empty_i && !stall_i;

    always_comb begin
        opcode = rv32i_opcode_e'(fetch_i.instr[6:0]);
        funct3 = fetch_i.instr[14:12];
        funct7 = fetch_i.instr[31:25];
        rs1    = fetch_i.instr[19:15];
        rs2    = fetch_i.instr[24:20];
        rd     = fetch_i.instr[11:7];

        i_imm = {{21{fetch_i.instr[31]}}, fetch_i.instr[30:20]};
        s_imm = {{21{fetch_i.instr[31]}}, fetch_i.instr[30:25], fetch_i.instr[11:7]};
        b_imm = {{20{fetch_i.instr[31]}}, fetch_i.instr[7], fetch_i.instr[30:25],
                 fetch_i.instr[11:8], 1'b0};
        u_imm = {fetch_i.instr[31:12], 12'h000};
        j_imm = {{12{fetch_i.instr[31]}}, fetch_i.instr[19:12], fetch_i.instr[20],
                 fetch_i.instr[30:21], 1'b0};
    end

    control_rom ctrl_rom (
        .opcode_i (opcode),
        .funct3_i (funct3),
        .funct7_i (funct7),
        .ctrl_o   (rom_ctrl)
    );

    regfile rf (
        .clk       (clk),
        .rst_i     (rst_i),
        .wb_i      (wb_i),
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .rs1_val_o (rs1_val),
        .rs2_val_o (rs2_val)
    );

    always_comb begin
        cmp_b = (rom_ctrl.cmpmux_sel == cmp_i_imm) ? i_imm : rs2_val;
        case (rom_ctrl.cmpop)
            beq:     cmp_res = (rs1_val == cmp_b);
            bne:     cmp_res = (rs1_val != cmp_b);
            blt:     cmp_res = ($signed(rs1_val) < $signed(cmp_b));
            bge:     cmp_res = ($signed(rs1_val) >= $signed(cmp_b));
            bltu:    cmp_res = (rs1_val < cmp_b);
            bgeu:    cmp_res = (rs1_val >= cmp_b);
            default: cmp_res = 1'b0;      // funct3 010/011 on a branch
        endcase
    end

    always_comb begin
        id_next.valid   = pop_o;
        id_next.pc      = fetch_i.pc;
        id_next.instr   = fetch_i.instr;
        id_next.ctrl    = flush_i ? nop_ctrl : rom_ctrl;
        id_next.rs1_val = rs1_val;
        id_next.rs2_val = rs2_val;
        id_next.i_imm   = i_imm;
        id_next.s_imm   = s_imm;
        id_next.b_imm   = b_imm;
        id_next.u_imm   = u_imm;
        id_next.j_imm   = j_imm;
        id_next.rs1     = rs1;
        id_next.rs2     = rs2;
        id_next.rd      = rd;
        id_next.br_en   = (opcode == op_br) && cmp_res;  // slt results stay out
        id_next.br_addr = fetch_i.pc + b_imm;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_ex_o.valid <= 1'b0;
        end else if (!stall_i) begin
            id_ex_o <= id_next;            // hold while execute stalls
        end
    end

endmodule : decode_stage

// File: rtl/decode_top.sv
module decode_top (
    input  logic                        clk,
    input  logic                        rst_i,
    input  rv32i_types_pkg::fetch_pkt_t fetch_i,
    output logic                        credit_o,
    input  rv32i_types_pkg::wb_pkt_t    wb_i,
    input  logic                        stall_i,
    input  logic                        flush_i,
    output rv32i_types_pkg::id_ex_t     id_ex_o
);
    import rv32i_types_pkg::*;

    fetch_pkt_t head;
    logic       not_empty;
    logic       pop;

    fetch_queue fetch_q (
        .clk         (clk),
        .rst_i       (rst_i),
        .fetch_i     (fetch_i),
        .pop_i       (pop),
        .head_o      (head),
        .not_empty_o (not_empty),
        .credit_o    (credit_o)
    );

    decode_stage decode (
        .clk         (clk),
        .rst_i       (rst_i),
        .fetch_i     (head),
        .not_empty_i (not_empty),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .wb_i        (wb_i),
        .pop_o       (pop),
        .id_ex_o     (id_ex_o)
    );

endmodule : decode_top

// File: verification/clk_gen.sv
module clk_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;          // 10 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (8) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule : clk_gen

// File: verification/decode_props.sv
`include "rv32i_macros.svh"

module decode_props (
    input logic                        clk,
    input logic                        rst_i,
    input rv32i_types_pkg::fetch_pkt_t fetch_i,
    input logic                        credit_i,
    input rv32i_types_pkg::wb_pkt_t    wb_i,
    input logic                        stall_i,
    input logic                        flush_i,
    input rv32i_types_pkg::id_ex_t     id_ex_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import rv32i_types_pkg::*;

    int           fails = 0;
    int           occ;                  // pushes not yet paid back by a credit
    word_t        shadow [`NUM_REGS];
    word_t        last_pc;
    logic         have_pc;
    logic         took;                 // ID/EX loaded at the previous edge
    logic         pend_empty;           // push into an empty queue at the previous edge
    logic         fresh;
    word_t        ins;
    word_t        exp_rs1;
    word_t        exp_rs2;
    word_t        exp_b_imm;
    logic         exp_br;
    logic [174:0] exp_fields;
    logic [174:0] got_fields;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            occ        <= 0;
            have_pc    <= 1'b0;
            took       <= 1'b0;
            pend_empty <= 1'b0;
            for (int i = 0; i < `NUM_REGS; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            occ        <= occ + int'(fetch_i.valid) - int'(credit_i);
            took       <= !stall_i;
            pend_empty <= fetch_i.valid && (occ == 0);
            if (wb_i.valid && wb_i.rd != '0) begin
                shadow[wb_i.rd] <= wb_i.data;   // post-write state is what decode read
            end
            if (fresh) begin
                last_pc <= id_ex_i.pc;
                have_pc <= 1'b1;
            end
        end
    end

    always_comb begin
        ins        = id_ex_i.instr;
        fresh      = took && id_ex_i.valid;
        exp_rs1    = shadow[ins[19:15]];
        exp_rs2    = shadow[ins[24:20]];
        exp_b_imm  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        // I, S, B, U, J immediates then rs1, rs2, rd
        exp_fields = {
            {{20{ins[31]}}, ins[31:20]},
            {{20{ins[31]}}, ins[31:25], ins[11:7]},
            exp_b_imm,
            {ins[31:12], 12'h000},
            {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0},
            ins[19:15], ins[24:20], ins[11:7]
        };
        got_fields = {id_ex_i.i_imm, id_ex_i.s_imm, id_ex_i.b_imm, id_ex_i.u_imm,
                      id_ex_i.j_imm, id_ex_i.rs1, id_ex_i.rs2, id_ex_i.rd};
        case (ins[14:12])
            3'b000:  exp_br = (exp_rs1 == exp_rs2);
            3'b001:  exp_br = (exp_rs1 != exp_rs2);
            3'b100:  exp_br = ($signed(exp_rs1) < $signed(exp_rs2));
            3'b101:  exp_br = ($signed(exp_rs1) >= $signed(exp_rs2));
            3'b110:  exp_br = (exp_rs1 < exp_rs2);
            3'b111:  exp_br = (exp_rs1 >= exp_rs2);
            default: exp_br = 1'b0;
        endcase
        if (ins[6:0] != op_br) begin
            exp_br = 1'b0;
        end
    end

    a_credit: assert property (@(posedge clk) disable iff (rst_i)
        occ <= `FQ_DEPTH && (!credit_i || occ > 0)) else begin
        $error("credit count out of range, %0d entries outstanding", $sampled(occ));
        fails++;
    end

    a_order: assert property (@(posedge clk) disable iff (rst_i)
        fresh && have_pc |-> id_ex_i.pc == last_pc + 32'd4) else begin
        $error("MISMATCH id_ex_o.pc got %h exp %h", $sampled(id_ex_i.pc),
               $sampled(last_pc) + 32'd4);
        fails++;
    end

    a_latency: assert property (@(posedge clk) disable iff (rst_i)
        pend_empty && !stall_i |=> id_ex_i.valid) else begin
        $error("no valid ID/EX packet two cycles after a push into an empty queue");
        fails++;
    end

    a_fields: assert property (@(posedge clk) disable iff (rst_i)
        id_ex_i.valid |-> got_fields == exp_fields) else begin
        $error("MISMATCH id_ex_o imm and index fields got %h exp %h",
               $sampled(got_fields), $sampled(exp_fields));
        fails++;
    end

    a_regs: assert property (@(posedge clk) disable iff (rst_i)
        fresh |-> id_ex_i.rs1_val == exp_rs1 && id_ex_i.rs2_val == exp_rs2) else begin
        $error("MISMATCH id_ex_o.rs1_val/rs2_val got %h %h exp %h %h",
               $sampled(id_ex_i.rs1_val), $sampled(id_ex_i.rs2_val),
               $sampled(exp_rs1), $sampled(exp_rs2));
        fails++;
    end

    a_br_en: assert property (@(posedge clk) disable iff (rst_i)
        fresh |-> id_ex_i.br_en == exp_br) else begin
        $error("MISMATCH id_ex_o.br_en got %h exp %h", $sampled(id_ex_i.br_en),
               $sampled(exp_br));
        fails++;
    end

    a_br_addr: assert property (@(posedge clk) disable iff (rst_i)
        id_ex_i.valid |-> id_ex_i.br_addr == id_ex_i.pc + exp_b_imm) else begin
        $error("MISMATCH id_ex_o.br_addr got %h exp %h", $sampled(id_ex_i.br_addr),
               $sampled(id_ex_i.pc) + $sampled(exp_b_imm));
        fails++;
    end

    a_stall: assert property (@(posedge clk) disable iff (rst_i)
        stall_i |=> $stable(id_ex_i)) else begin
        $error("ID/EX packet changed while stall_i was high");
        fails++;
    end

    a_flush: assert property (@(posedge clk) disable iff (rst_i)
        credit_i && flush_i |=> !id_ex_i.ctrl.load_regfile && !id_ex_i.ctrl.mem_read
            && !id_ex_i.ctrl.mem_write && id_ex_i.ctrl.mem_byte_en == 4'h0) else begin
        $error("MISMATCH id_ex_o.ctrl after flush got %h", $sampled(id_ex_i.ctrl));
        fails++;
    end

endmodule : decode_props

// File: verification/decode_tb.sv
`include "rv32i_macros.svh"

module decode_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv32i_types_pkg::*;

    localparam int N_INSTR = 200;

    logic       clk;
    logic       rst;
    fetch_pkt_t fetch;
    logic       credit;
    wb_pkt_t    wb;
    logic       stall;
    logic       flush;
    id_ex_t     id_ex;

    int   credits;                      // held by the fetch side
    int   err_cnt;
    logic timed_out;

    clk_gen clocks (
        .clk_o (clk),
        .rst_o (rst)
    );

    decode_top DUT (
        .clk      (clk),
        .rst_i    (rst),
        .fetch_i  (fetch),
        .credit_o (credit),
        .wb_i     (wb),
        .stall_i  (stall),
        .flush_i  (flush),
        .id_ex_o  (id_ex)
    );

    bind decode_top decode_props props_chk (
        .clk      (clk),
        .rst_i    (rst_i),
        .fetch_i  (fetch_i),
        .credit_i (credit_o),
        .wb_i     (wb_i),
        .stall_i  (stall_i),
        .flush_i  (flush_i),
        .id_ex_i  (id_ex_o)
    );

    // credit comes back at the rising edge, inputs change on the falling one
    task automatic next_cycle();
        @(posedge clk);
        if (credit) begin
            credits++;
        end
        if (credits > `FQ_DEPTH) begin
            $display("ERROR: more credits returned than the fetch side ever held");
            err_cnt++;
        end
        @(negedge clk);
    endtask

    function automatic word_t make_instr();
        rv32i_opcode_e mix [7] = '{op_imm, op_reg, op_br, op_load, op_store, op_lui, op_jal};
        word_t         w;
        w      = $urandom;
        w[6:0] = mix[$urandom % 7];
        if (w[6:0] == op_reg) begin
            w[31:25] = {1'b0, w[30], 5'b00000};   // add/sub, srl/sra
        end
        if (w[6:0] == op_br) begin
            w[14] = w[14] | w[13];                // keep funct3 a real branch
            if (w[8]) begin
                w[24:20] = w[19:15];              // equal operands now and then
            end
        end
        return w;
    endfunction

    task automatic wait_reset_release();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (rst !== 1'b0 && n < 20);
        if (rst !== 1'b0) begin
            $display("ERROR: reset still asserted after 20 cycles");
            err_cnt++;
            timed_out = 1'b1;
        end
    endtask

    task automatic fill_regs();
        for (int r = 1; r < `NUM_REGS; r++) begin
            wb.valid = 1'b1;
            wb.rd    = reg_idx_t'(r);
            wb.data  = $urandom;
            next_cycle();
        end
        wb.valid = 1'b0;
    endtask

    task automatic run_stream();
        int    pushed;
        int    cycles;
        word_t pc;
        pushed = 0;
        cycles = 0;
        pc     = '0;
        while (pushed < N_INSTR && cycles < 20 * N_INSTR) begin
            stall       = ($urandom % 5) == 0;
            flush       = ($urandom % 8) == 0;
            wb.valid    = ($urandom % 6) == 0;    // writebacks race with decode reads
            wb.rd       = reg_idx_t'($urandom);
            wb.data     = $urandom;
            fetch.valid = 1'b0;
            if (credits > 0 && ($urandom % 4) != 0) begin
                fetch.valid = 1'b1;
                fetch.pc    = pc;
                fetch.instr = make_instr();
                credits--;
                pushed++;
                pc += 32'd4;
            end
            next_cycle();
            cycles++;
        end
        if (pushed < N_INSTR) begin
            $display("ERROR: only %0d of %0d instructions pushed before the timeout",
                     pushed, N_INSTR);
            err_cnt++;
            timed_out = 1'b1;
        end
    endtask

    task automatic drain_queue();
        int n;
        n           = 0;
        stall       = 1'b0;
        flush       = 1'b0;
        fetch.valid = 1'b0;
        wb.valid    = 1'b0;
        while (credits < `FQ_DEPTH && n < 50) begin
            next_cycle();
            n++;
        end
        if (credits < `FQ_DEPTH) begin
            $display("ERROR: queue did not drain, %0d credits still missing",
                     `FQ_DEPTH - credits);
            err_cnt++;
            timed_out = 1'b1;
        end
        next_cycle();
        next_cycle();                             // last packet leaves ID/EX
    endtask

    initial begin
        fetch     = '0;
        wb        = '0;
        stall     = 1'b0;
        flush     = 1'b0;
        credits   = `FQ_DEPTH;
        err_cnt   = 0;
        timed_out = 1'b0;
        void'($urandom(32'h2ba5));
        wait_reset_release();
        if (!timed_out) fill_regs();
        if (!timed_out) run_stream();
        if (!timed_out) drain_queue();
        $display("errors: testbench %0d, assertions %0d", err_cnt, DUT.props_chk.fails);
        if (err_cnt == 0 && DUT.props_chk.fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : decode_tb

// File: vlog.f
+incdir+rtl
rtl/rv32i_types_pkg.sv
rtl/fetch_queue.sv
rtl/control_rom.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/decode_top.sv
verification/clk_gen.sv
verification/decode_props.sv
verification/decode_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= decode_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf $(OBJ_DIR)
